//--- rtl/sdctrl_pkg.sv
package sdctrl_pkg;

    // SD command indices
    typedef logic [5:0] cmd_idx_t;
    localparam cmd_idx_t CMD0 = 6'd0;   // GO_IDLE_STATE
    localparam cmd_idx_t CMD8 = 6'd8;   // SEND_IF_COND

    typedef enum logic {
        R_NONE,
        R1                              // 48-bit response
    } resp_kind_t;

    typedef enum logic {
        SDSTATE_PRE_INIT,
        SDSTATE_IDLE
    } sdstate_t;

    typedef enum logic [2:0] {
        INITSTATE_CMD0,
        INITSTATE_CMD8,
        INITSTATE_WAIT_RESP,
        INITSTATE_CHECK,
        INITSTATE_ERROR,
        INITSTATE_DONE
    } initstate_t;

    typedef enum logic [3:0] {
        CMDSTATE_IDLE,
        CMDSTATE_REQ_START,
        CMDSTATE_REQ_BODY,
        CMDSTATE_REQ_CRC,
        CMDSTATE_REQ_STOP,
        CMDSTATE_RESP_WAIT,
        CMDSTATE_RESP_BODY,
        CMDSTATE_RESP_CRC,
        CMDSTATE_RESP_STOP
    } cmdstate_t;

    typedef enum logic [3:0] {
        CMDERR_NONE                = 4'd0,
        CMDERR_NO_RESPONSE         = 4'd1,
        CMDERR_WRONG_RESP_STARTBIT = 4'd2,
        CMDERR_WRONG_RESP_CMD      = 4'd3,
        CMDERR_WRONG_RESP_CRC      = 4'd4
    } cmderr_t;

    // Low 14 bits of the CMD8 argument
    typedef struct packed {
        logic       pcie_12v_support;
        logic       pcie_available;
        logic [3:0] voltage_supply;
        logic [7:0] check_pattern;
    } ifcond_t;

    localparam logic [3:0] REG_CLKDIV   = 4'd0;
    localparam logic [3:0] REG_CONTROL  = 4'd1;  // [0] clock enable, [1] clear cmderr
    localparam logic [3:0] REG_IFCOND   = 4'd2;
    localparam logic [3:0] REG_WATCHDOG = 4'd3;
    localparam logic [3:0] REG_STATUS   = 4'd4;
    localparam logic [3:0] REG_RESP_CMD = 4'd5;
    localparam logic [3:0] REG_RESP_REG = 4'd6;
    localparam logic [3:0] REG_RESP_CRC = 4'd7;

    localparam logic [17:0] CMD8_ARG_RESERVED = 18'h00000;

endpackage

//--- rtl/sdctrl_cmd_if.sv
`timescale 1ns/100ps

interface sdctrl_cmd_if import sdctrl_pkg::*; ();

    // Request from the initialiser
    logic        req_valid;
    cmd_idx_t    req_cmd;
    logic [31:0] req_arg;
    resp_kind_t  req_rn;
    logic        req_ready;

    // Response with a single-cycle resp_valid pulse
    logic        resp_valid;
    cmd_idx_t    resp_cmd;
    logic [31:0] resp_reg;
    logic [6:0]  resp_crc7_rx;
    logic [6:0]  resp_crc7_calc;

    cmdstate_t   cmdstate;
    cmderr_t     cmderr;
    logic        clear_cmderr;

    modport init (
        output req_valid, req_cmd, req_arg, req_rn,
        input  req_ready, resp_valid, resp_reg, cmderr
    );

    modport trx (
        input  req_valid, req_cmd, req_arg, req_rn, clear_cmderr,
        output req_ready, resp_valid, resp_cmd, resp_reg, resp_crc7_rx, resp_crc7_calc,
        output cmdstate, cmderr
    );

    modport mon (
        input  resp_cmd, resp_reg, resp_crc7_rx, resp_crc7_calc, cmdstate, cmderr,
        output clear_cmderr
    );

endinterface

//--- rtl/sdctrl_crc7.sv
`timescale 1ns/100ps

module sdctrl_crc7 (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,     // Start of frame
    input  logic       i_next,
    input  logic       i_dat,
    output logic [6:0] o_crc7
);

    logic fb;

    assign fb = i_dat ^ o_crc7[6];

    // Polynomial x^7 + x^3 + 1
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc7 <= '0;
        end else if (i_clear) begin
            o_crc7 <= '0;
        end else if (i_next) begin
            o_crc7 <= {o_crc7[5:3], o_crc7[2] ^ fb, o_crc7[1:0], fb};
        end
    end

endmodule

//--- rtl/sdctrl_regs.sv
`timescale 1ns/100ps

module sdctrl_regs import sdctrl_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_reg_we,
    input  logic [3:0]  i_reg_addr,
    input  logic [31:0] i_reg_wdata,
    output logic [31:0] o_reg_rdata,
    output logic        o_sclk,
    output logic        o_sck_posedge,    // Cycle before o_sclk rises
    output logic        o_sck_negedge,    // Cycle before o_sclk falls
    output logic [15:0] o_watchdog,
    output ifcond_t     o_ifcond,
    input  sdstate_t    i_sdstate,
    input  initstate_t  i_initstate,
    sdctrl_cmd_if.mon   cmd
);

    logic [15:0] clkdiv;          // Half period minus one
    logic        sclk_ena;
    logic [15:0] div_cnt;
    logic        div_wrap;
    logic        clear_pulse;

    assign div_wrap         = sclk_ena && (div_cnt >= clkdiv);
    assign o_sck_posedge    = div_wrap && !o_sclk;
    assign o_sck_negedge    = div_wrap && o_sclk;
    assign cmd.clear_cmderr = clear_pulse;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            clkdiv      <= 16'd4;
            sclk_ena    <= 1'b0;
            o_watchdog  <= 16'd1000;
            o_ifcond    <= '{pcie_12v_support: 1'b0, pcie_available: 1'b0,
                             voltage_supply: 4'h1, check_pattern: 8'hAA};
            clear_pulse <= 1'b0;
        end else begin
            clear_pulse <= 1'b0;
            if (i_reg_we) begin
                case (i_reg_addr)
                    REG_CLKDIV:   clkdiv <= i_reg_wdata[15:0];
                    REG_CONTROL: begin
                        sclk_ena    <= i_reg_wdata[0];
                        clear_pulse <= i_reg_wdata[1];   // Write-one pulse of one cycle
                    end
                    REG_IFCOND:   o_ifcond   <= ifcond_t'(i_reg_wdata[13:0]);
                    REG_WATCHDOG: o_watchdog <= i_reg_wdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    // SD clock divider
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            div_cnt <= '0;
            o_sclk  <= 1'b0;
        end else if (!sclk_ena) begin
            div_cnt <= '0;              // Counter restarts whenever the clock is off
        end else if (div_wrap) begin
            div_cnt <= '0;
            o_sclk  <= ~o_sclk;
        end else begin
            div_cnt <= div_cnt + 16'd1;
        end
    end

    // Read-back
    always_comb begin
        case (i_reg_addr)
            REG_CLKDIV:   o_reg_rdata = {16'h0, clkdiv};
            REG_CONTROL:  o_reg_rdata = {31'h0, sclk_ena};
            REG_IFCOND:   o_reg_rdata = {18'h0, o_ifcond};
            REG_WATCHDOG: o_reg_rdata = {16'h0, o_watchdog};
            REG_STATUS: begin
                o_reg_rdata = {16'h0, cmd.cmderr, cmd.cmdstate,
                               1'b0, i_initstate, 3'b000, i_sdstate};
            end
            REG_RESP_CMD: o_reg_rdata = {26'h0, cmd.resp_cmd};
            REG_RESP_REG: o_reg_rdata = cmd.resp_reg;
            REG_RESP_CRC: begin
                o_reg_rdata = {17'h0, cmd.resp_crc7_rx, 1'b0, cmd.resp_crc7_calc};
            end
            default:      o_reg_rdata = '0;
        endcase
    end

endmodule

//--- rtl/sdctrl_init.sv
`timescale 1ns/100ps

module sdctrl_init import sdctrl_pkg::*; #(
    parameter int PREINIT_CLOCKS = 75
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_sck_posedge,
    input  ifcond_t     i_ifcond,
    output sdstate_t    o_sdstate,
    output initstate_t  o_initstate,
    sdctrl_cmd_if.init  cmd
);

    localparam int CNT_W = $clog2(PREINIT_CLOCKS + 1);

    logic [CNT_W-1:0] clkcnt;
    initstate_t       initstate_next;    // Where WAIT_RESP goes on resp_valid
    logic [11:0]      resp_low;          // VHS and check pattern echo

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_sdstate      <= SDSTATE_PRE_INIT;
            o_initstate    <= INITSTATE_CMD0;
            initstate_next <= INITSTATE_CMD0;
            clkcnt         <= '0;
            cmd.req_valid  <= 1'b0;
            cmd.req_cmd    <= CMD0;
            cmd.req_arg    <= '0;
            cmd.req_rn     <= R_NONE;
            resp_low       <= '0;
        end else begin
            if (cmd.req_valid && cmd.req_ready) begin
                cmd.req_valid <= 1'b0;
            end
            case (o_sdstate)
                SDSTATE_PRE_INIT: begin
                    // CMD stays high while the card gets its start-up clocks
                    if (i_sck_posedge) begin
                        clkcnt <= clkcnt + 1'b1;
                        if (clkcnt == CNT_W'(PREINIT_CLOCKS - 1)) begin
                            o_sdstate <= SDSTATE_IDLE;
                        end
                    end
                end
                default: begin
                    case (o_initstate)
                        INITSTATE_CMD0: begin
                            cmd.req_valid  <= 1'b1;
                            cmd.req_cmd    <= CMD0;
                            cmd.req_arg    <= '0;
                            cmd.req_rn     <= R1;
                            o_initstate    <= INITSTATE_WAIT_RESP;
                            initstate_next <= INITSTATE_CMD8;
                        end
                        INITSTATE_CMD8: begin
                            if (cmd.cmderr != CMDERR_NONE) begin
                                o_initstate <= INITSTATE_ERROR;   // CMD0 failed
                            end else begin
                                cmd.req_valid  <= 1'b1;
                                cmd.req_cmd    <= CMD8;
                                cmd.req_arg    <= {CMD8_ARG_RESERVED, i_ifcond};
                                cmd.req_rn     <= R1;
                                o_initstate    <= INITSTATE_WAIT_RESP;
                                initstate_next <= INITSTATE_CHECK;
                            end
                        end
                        INITSTATE_WAIT_RESP: begin
                            if (cmd.resp_valid) begin
                                resp_low    <= cmd.resp_reg[11:0];
                                o_initstate <= initstate_next;
                            end
                        end
                        INITSTATE_CHECK: begin
                            // The card has to echo voltage range and pattern
                            if (cmd.cmderr == CMDERR_NONE &&
                                resp_low == {i_ifcond.voltage_supply,
                                             i_ifcond.check_pattern}) begin
                                o_initstate <= INITSTATE_DONE;
                            end else begin
                                o_initstate <= INITSTATE_ERROR;
                            end
                        end
                        default: ;   // ERROR and DONE are final
                    endcase
                end
            endcase
        end
    end

endmodule

//--- rtl/sdctrl_cmd_transmitter.sv
`timescale 1ns/100ps

module sdctrl_cmd_transmitter import sdctrl_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_sclk_posedge,
    input  logic        i_sclk_negedge,
    input  logic        i_cmd,
    output logic        o_cmd,
    output logic        o_cmd_dir,       // 1 = input, card drives CMD
    input  logic [15:0] i_watchdog,
    sdctrl_cmd_if.trx   cmd
);

    cmdstate_t   state;
    logic [5:0]  bitcnt;
    logic [39:0] tx_shift;      // Start bit, transmit bit, index, argument
    logic [38:0] rx_shift;      // Transmit bit, index, argument
    logic [6:0]  crc_rx;
    cmd_idx_t    req_cmd;
    resp_kind_t  req_rn;
    logic [15:0] wdog_cnt;
    logic        crc_clear;
    logic        crc_next;
    logic        crc_dat;
    logic [6:0]  crc7;

    assign cmd.req_ready = (state == CMDSTATE_IDLE);
    assign cmd.cmdstate  = state;

    // CRC held at zero between frames
    // A zero start bit would leave it unchanged, so receive starts after it
    assign crc_clear = (state == CMDSTATE_IDLE) || (state == CMDSTATE_RESP_WAIT);

    always_comb begin
        crc_next = 1'b0;
        crc_dat  = 1'b0;
        if (i_sclk_negedge &&
            (state == CMDSTATE_REQ_START || state == CMDSTATE_REQ_BODY)) begin
            crc_next = 1'b1;
            crc_dat  = tx_shift[39];
        end else if (i_sclk_posedge && state == CMDSTATE_RESP_BODY) begin
            crc_next = 1'b1;
            crc_dat  = i_cmd;
        end
    end

    sdctrl_crc7 crc7_i (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc7)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state              <= CMDSTATE_IDLE;
            bitcnt             <= '0;
            tx_shift           <= '0;
            rx_shift           <= '0;
            crc_rx             <= '0;
            req_cmd            <= CMD0;
            req_rn             <= R_NONE;
            wdog_cnt           <= '0;
            o_cmd              <= 1'b1;
            o_cmd_dir          <= 1'b0;
            cmd.resp_valid     <= 1'b0;
            cmd.resp_cmd       <= '0;
            cmd.resp_reg       <= '0;
            cmd.resp_crc7_rx   <= '0;
            cmd.resp_crc7_calc <= '0;
            cmd.cmderr         <= CMDERR_NONE;
        end else begin
            cmd.resp_valid <= 1'b0;
            if (cmd.clear_cmderr) begin
                cmd.cmderr <= CMDERR_NONE;
            end
            case (state)
                CMDSTATE_IDLE: begin
                    if (cmd.req_valid) begin
                        tx_shift <= {2'b01, cmd.req_cmd, cmd.req_arg};
                        req_cmd  <= cmd.req_cmd;
                        req_rn   <= cmd.req_rn;
                        bitcnt   <= 6'd40;
                        state    <= CMDSTATE_REQ_START;
                    end
                end
                CMDSTATE_REQ_START, CMDSTATE_REQ_BODY: begin
                    if (i_sclk_negedge) begin
                        o_cmd    <= tx_shift[39];
                        tx_shift <= {tx_shift[38:0], 1'b0};
                        bitcnt   <= bitcnt - 6'd1;
                        state    <= CMDSTATE_REQ_BODY;
                        if (bitcnt == 6'd1) begin
                            bitcnt <= 6'd7;
                            state  <= CMDSTATE_REQ_CRC;
                        end
                    end
                end
                CMDSTATE_REQ_CRC: begin
                    if (i_sclk_negedge) begin
                        o_cmd  <= crc7[bitcnt[2:0] - 3'd1];   // MSB first
                        bitcnt <= bitcnt - 6'd1;
                        if (bitcnt == 6'd1) begin
                            state <= CMDSTATE_REQ_STOP;
                        end
                    end
                end
                CMDSTATE_REQ_STOP: begin
                    if (i_sclk_negedge) begin
                        if (bitcnt == 6'd0) begin
                            o_cmd  <= 1'b1;        // End bit
                            bitcnt <= 6'd1;
                        end else if (req_rn == R_NONE) begin
                            cmd.resp_valid <= 1'b1;
                            state          <= CMDSTATE_IDLE;
                        end else begin
                            o_cmd_dir <= 1'b1;
                            wdog_cnt  <= '0;
                            state     <= CMDSTATE_RESP_WAIT;
                        end
                    end
                end
                CMDSTATE_RESP_WAIT: begin
                    if (i_sclk_posedge) begin
                        if (!i_cmd) begin
                            bitcnt <= 6'd39;
                            state  <= CMDSTATE_RESP_BODY;
                        end else if ({1'b0, wdog_cnt} + 17'd1 >= {1'b0, i_watchdog}) begin
                            cmd.cmderr     <= CMDERR_NO_RESPONSE;
                            cmd.resp_valid <= 1'b1;
                            o_cmd_dir      <= 1'b0;
                            state          <= CMDSTATE_IDLE;
                        end else begin
                            wdog_cnt <= wdog_cnt + 16'd1;
                        end
                    end
                end
                CMDSTATE_RESP_BODY: begin
                    if (i_sclk_posedge) begin
                        rx_shift <= {rx_shift[37:0], i_cmd};
                        bitcnt   <= bitcnt - 6'd1;
                        if (bitcnt == 6'd1) begin
                            bitcnt <= 6'd7;
                            state  <= CMDSTATE_RESP_CRC;
                        end
                    end
                end
                CMDSTATE_RESP_CRC: begin
                    if (i_sclk_posedge) begin
                        crc_rx <= {crc_rx[5:0], i_cmd};
                        bitcnt <= bitcnt - 6'd1;
                        if (bitcnt == 6'd1) begin
                            state <= CMDSTATE_RESP_STOP;
                        end
                    end
                end
                CMDSTATE_RESP_STOP: begin
                    if (i_sclk_posedge) begin
                        cmd.resp_valid     <= 1'b1;
                        cmd.resp_cmd       <= rx_shift[37:32];
                        cmd.resp_reg       <= rx_shift[31:0];
                        cmd.resp_crc7_rx   <= crc_rx;
                        cmd.resp_crc7_calc <= crc7;
                        o_cmd_dir          <= 1'b0;
                        state              <= CMDSTATE_IDLE;
                        // Checks in priority order
                        if (rx_shift[38]) begin
                            cmd.cmderr <= CMDERR_WRONG_RESP_STARTBIT;
                        end else if (rx_shift[37:32] != req_cmd) begin
                            cmd.cmderr <= CMDERR_WRONG_RESP_CMD;
                        end else if (crc_rx != crc7) begin
                            cmd.cmderr <= CMDERR_WRONG_RESP_CRC;
                        end
                    end
                end
                default: state <= CMDSTATE_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/sdctrl.sv
`timescale 1ns/100ps

module sdctrl import sdctrl_pkg::*; #(
    parameter int PREINIT_CLOCKS = 75
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_reg_we,
    input  logic [3:0]  i_reg_addr,
    input  logic [31:0] i_reg_wdata,
    output logic [31:0] o_reg_rdata,
    output logic        o_sclk,
    input  logic        i_cmd,
    output logic        o_cmd,
    output logic        o_cmd_dir
);

    logic        sck_posedge;
    logic        sck_negedge;
    logic [15:0] watchdog;
    ifcond_t     ifcond;
    sdstate_t    sdstate;
    initstate_t  initstate;

    sdctrl_cmd_if cmd_if ();

    sdctrl_regs regs_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_reg_we      (i_reg_we),
        .i_reg_addr    (i_reg_addr),
        .i_reg_wdata   (i_reg_wdata),
        .o_reg_rdata   (o_reg_rdata),
        .o_sclk        (o_sclk),
        .o_sck_posedge (sck_posedge),
        .o_sck_negedge (sck_negedge),
        .o_watchdog    (watchdog),
        .o_ifcond      (ifcond),
        .i_sdstate     (sdstate),
        .i_initstate   (initstate),
        .cmd           (cmd_if.mon)
    );

    sdctrl_init #(
        .PREINIT_CLOCKS (PREINIT_CLOCKS)
    ) init_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_sck_posedge (sck_posedge),
        .i_ifcond      (ifcond),
        .o_sdstate     (sdstate),
        .o_initstate   (initstate),
        .cmd           (cmd_if.init)
    );

    sdctrl_cmd_transmitter cmdtrx_i (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_sclk_posedge (sck_posedge),
        .i_sclk_negedge (sck_negedge),
        .i_cmd          (i_cmd),
        .o_cmd          (o_cmd),
        .o_cmd_dir      (o_cmd_dir),
        .i_watchdog     (watchdog),
        .cmd            (cmd_if.trx)
    );

endmodule

//--- dv/sd_card_model.sv
`timescale 1ns/100ps

module sd_card_model (
    input  logic        i_nrst,
    input  logic        i_sclk,
    input  logic        i_host_cmd,     // CMD as driven by the host
    input  logic        i_cmd_dir,      // 1 = card owns the line
    input  logic [2:0]  i_behaviour,    // 0 OK, 1 SILENT, 2 BAD_CRC, 3 BAD_ECHO, 4 BAD_INDEX
    input  logic [31:0] i_cmd8_arg,
    output logic        o_cmd,
    output logic        o_err,
    output logic [3:0]  o_frames,
    output logic [15:0] o_preinit_cnt
);

    logic        rx_busy;
    logic [5:0]  rx_cnt;
    logic [45:0] rx_sr;
    logic [47:0] resp_frame;
    logic [7:0]  resp_seq;
    logic [7:0]  tx_seq;
    logic        tx_busy;
    logic [1:0]  tx_wait;
    logic [5:0]  tx_idx;
    logic [47:0] tx_frame;
    logic        drive;

    assign o_cmd = i_cmd_dir ? drive : 1'b1;   // Pull-up when nobody drives

    // x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = 7'h00;
        for (int k = 39; k >= 0; k--) begin
            fb  = bits[k] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // Command receive on rising SD clock
    always @(posedge i_sclk or negedge i_nrst) begin : rx_proc
        logic [47:0] frame;
        logic [5:0]  rsp_idx;
        logic [31:0] rsp_arg;
        logic [6:0]  rsp_crc;
        if (!i_nrst) begin
            rx_busy       <= 1'b0;
            rx_cnt        <= '0;
            rx_sr         <= '0;
            o_frames      <= '0;
            o_preinit_cnt <= '0;
            o_err         <= 1'b0;
            resp_frame    <= '1;
            resp_seq      <= '0;
        end else if (!rx_busy) begin
            if (!i_host_cmd && !i_cmd_dir) begin
                rx_busy <= 1'b1;
                rx_cnt  <= 6'd1;
            end else if (o_frames == 0 && i_host_cmd) begin
                o_preinit_cnt <= o_preinit_cnt + 16'd1;
            end
        end else begin
            rx_sr  <= {rx_sr[44:0], i_host_cmd};
            rx_cnt <= rx_cnt + 6'd1;
            if (rx_cnt == 6'd47) begin
                frame   = {1'b0, rx_sr, i_host_cmd};
                rx_busy <= 1'b0;
                if (frame[46] != 1'b1 || frame[0] != 1'b1) begin
                    $display("card model: bad transmit or end bit in frame %0d", o_frames);
                    o_err <= 1'b1;
                end
                if (frame[7:1] != crc7_of(frame[47:8])) begin
                    $display("card model: CRC7 of frame %0d is wrong", o_frames);
                    o_err <= 1'b1;
                end
                if (o_frames == 0 && frame[45:40] != 6'd0) begin
                    $display("card model: first command is not CMD0");
                    o_err <= 1'b1;
                end
                if (o_frames == 1 && (frame[45:40] != 6'd8 || frame[39:8] != i_cmd8_arg)) begin
                    $display("card model: second command is not CMD8 with the written argument");
                    o_err <= 1'b1;
                end
                if (o_frames > 1) begin
                    $display("card model: unexpected extra command");
                    o_err <= 1'b1;
                end
                o_frames <= o_frames + 4'd1;
                rsp_idx  = frame[45:40];
                rsp_arg  = frame[39:8];
                if (o_frames == 1 && i_behaviour == 3'd4) rsp_idx = rsp_idx ^ 6'h01;
                if (o_frames == 1 && i_behaviour == 3'd3) rsp_arg = rsp_arg ^ 32'hFF;
                rsp_crc = crc7_of({2'b00, rsp_idx, rsp_arg});
                if (o_frames == 1 && i_behaviour == 3'd2) rsp_crc = rsp_crc ^ 7'h01;
                if (!(o_frames == 1 && i_behaviour == 3'd1)) begin
                    resp_frame <= {2'b00, rsp_idx, rsp_arg, rsp_crc, 1'b1};
                    resp_seq   <= resp_seq + 8'd1;
                end
            end
        end
    end

    // Response drive on falling SD clock, after a short turnaround
    always @(negedge i_sclk or negedge i_nrst) begin
        if (!i_nrst) begin
            tx_busy  <= 1'b0;
            tx_seq   <= '0;
            tx_wait  <= '0;
            tx_idx   <= '0;
            tx_frame <= '1;
            drive    <= 1'b1;
        end else if (!tx_busy) begin
            drive <= 1'b1;
            if (resp_seq != tx_seq) begin
                tx_seq   <= resp_seq;
                tx_frame <= resp_frame;
                tx_busy  <= 1'b1;
                tx_wait  <= 2'd1;
                tx_idx   <= 6'd47;
            end
        end else if (tx_wait != 0) begin
            tx_wait <= tx_wait - 2'd1;
        end else begin
            drive <= tx_frame[tx_idx];
            if (tx_idx == 0) tx_busy <= 1'b0;
            else tx_idx <= tx_idx - 6'd1;
        end
    end

endmodule

//--- dv/tb_sdctrl.sv
`timescale 1ns/100ps

module tb_sdctrl import sdctrl_pkg::*; ;

    localparam int PREINIT_CLOCKS = 75;
    localparam int MAX_TESTS      = 32;
    localparam int MARGIN         = 4000;   // Reset and register access per test

    logic        clk;
    logic        nrst;
    logic        reg_we;
    logic [3:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        sclk;
    logic        cmd_to_dut;
    logic        cmd_from_dut;
    logic        cmd_dir;
    logic [2:0]  behaviour;
    logic [31:0] cmd8_arg;
    logic        card_err;
    logic [3:0]  card_frames;
    logic [15:0] preinit_cnt;
    longint      cycles = 0;
    longint      cycle_limit = 0;

    logic [13:0] t_ifcond [MAX_TESTS];
    int          t_wdog   [MAX_TESTS];
    int          t_beh    [MAX_TESTS];
    int          t_state  [MAX_TESTS];
    int          t_err    [MAX_TESTS];
    logic [31:0] t_resp   [MAX_TESTS];
    int          ntests;
    int          wdog_max;

    always #4 clk = ~clk;

    sdctrl dut_i (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_reg_we    (reg_we),
        .i_reg_addr  (reg_addr),
        .i_reg_wdata (reg_wdata),
        .o_reg_rdata (reg_rdata),
        .o_sclk      (sclk),
        .i_cmd       (cmd_to_dut),
        .o_cmd       (cmd_from_dut),
        .o_cmd_dir   (cmd_dir)
    );

    sd_card_model card_i (
        .i_nrst        (nrst),
        .i_sclk        (sclk),
        .i_host_cmd    (cmd_from_dut),
        .i_cmd_dir     (cmd_dir),
        .i_behaviour   (behaviour),
        .i_cmd8_arg    (cmd8_arg),
        .o_cmd         (cmd_to_dut),
        .o_err         (card_err),
        .o_frames      (card_frames),
        .o_preinit_cnt (preinit_cnt)
    );

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            $display("[ERROR] %0t: %s", $time, msg);
            abort_run();
        end
    endtask

    // Index field of the last response the card model sends
    function automatic logic [5:0] expected_resp_cmd(input int beh);
        logic [5:0] idx;
        case (beh)
            1:       idx = 6'd0;    // CMD0 echo stays when CMD8 goes unanswered
            4:       idx = 6'd9;    // Card flips the low index bit
            default: idx = 6'd8;
        endcase
        return idx;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
        check(!card_err, "card model rejected a command frame");
    end

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        reg_addr = addr;
        @(negedge clk);
        data = reg_rdata;        // Stable since the last rising edge
    endtask

    task automatic apply_reset();
        @(negedge clk);
        nrst = 1'b0;
        repeat (16) @(negedge clk);
        nrst = 1'b1;
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        int    p12, pav, vhs, pat, wd, beh, st, er;
        logic [31:0] rsp;
        string line;
        fd = $fopen("dv/sdctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file dv/sdctrl_patterns.txt");
            abort_run();
        end
        ntests   = 0;
        wdog_max = 0;
        while (!$feof(fd) && ntests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%d %d %h %h %d %d %d %d %h",
                        p12, pav, vhs, pat, wd, beh, st, er, rsp);
            if (n != 9) continue;
            t_ifcond[ntests] = {p12[0], pav[0], vhs[3:0], pat[7:0]};
            t_wdog[ntests]   = wd;
            t_beh[ntests]    = beh;
            t_state[ntests]  = st;
            t_err[ntests]    = er;
            t_resp[ntests]   = rsp;
            if (wd > wdog_max) wdog_max = wd;
            ntests++;
        end
        $fclose(fd);
        if (ntests == 0) begin
            $display("The pattern file holds no test lines");
            abort_run();
        end
    endtask

    task automatic run_test(input int i);
        logic [31:0] st;
        logic [31:0] data;
        int          clkdiv;
        clkdiv = 1 + ($urandom % 3);
        @(negedge clk);
        behaviour = t_beh[i][2:0];
        cmd8_arg  = {18'h0, t_ifcond[i]};
        apply_reset();
        write_reg(REG_CLKDIV, clkdiv);
        write_reg(REG_IFCOND, {18'h0, t_ifcond[i]});
        write_reg(REG_WATCHDOG, t_wdog[i]);
        write_reg(REG_CONTROL, 32'h1);
        read_reg(REG_STATUS, st);
        check(st[0] == 1'b0, $sformatf("test %0d: SD state is not PRE_INIT at start", i));
        do begin
            read_reg(REG_STATUS, st);
        end while (st[6:4] != 3'd5 && st[6:4] != 3'd4);   // DONE or ERROR
        check(st[6:4] == t_state[i],
              $sformatf("test %0d: initstate %0d, expected %0d", i, st[6:4], t_state[i]));
        check(st[15:12] == t_err[i],
              $sformatf("test %0d: cmderr %0d, expected %0d", i, st[15:12], t_err[i]));
        check(st[11:8] == 4'd0,
              $sformatf("test %0d: cmdstate %0d, expected IDLE", i, st[11:8]));
        check(preinit_cnt >= PREINIT_CLOCKS,
              $sformatf("test %0d: only %0d pre-init clocks", i, preinit_cnt));
        check(card_frames == 4'd2, $sformatf("test %0d: %0d frames seen", i, card_frames));
        read_reg(REG_RESP_REG, data);
        check(data == t_resp[i],
              $sformatf("test %0d: RESP_REG %h, expected %h", i, data, t_resp[i]));
        read_reg(REG_RESP_CMD, data);
        check(data == {26'h0, expected_resp_cmd(t_beh[i])},
              $sformatf("test %0d: RESP_CMD %0d, expected %0d", i, data,
                        expected_resp_cmd(t_beh[i])));
        if (t_beh[i] == 2) begin
            read_reg(REG_RESP_CRC, data);
            check(data[14:8] != data[6:0],
                  $sformatf("test %0d: received and calculated CRC7 match", i));
        end
        if (t_err[i] != 0) begin
            write_reg(REG_CONTROL, 32'h3);              // Keep clock on, clear error
            read_reg(REG_STATUS, st);
            check(st[15:12] == 4'd0, $sformatf("test %0d: cmderr not cleared", i));
        end
    endtask

    initial begin
        clk       = 1'b0;
        nrst      = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        behaviour = '0;
        cmd8_arg  = '0;
        void'($urandom(87494));
        load_patterns();
        cycle_limit = longint'(ntests) * (PREINIT_CLOCKS + 2 * (48 + wdog_max + 48)) * 2 * 4
                      + longint'(ntests) * MARGIN;
        for (int i = 0; i < ntests; i++) begin
            run_test(i);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- dv/sdctrl_patterns.txt
# pcie_12v pcie_avail voltage(hex) pattern(hex) watchdog behaviour initstate cmderr resp(hex)
# behaviour: 0 OK, 1 SILENT, 2 BAD_CRC, 3 BAD_ECHO, 4 BAD_INDEX; initstate 4 ERROR, 5 DONE
0 0 1 AA 1000 0 5 0 000001AA
1 0 1 5C 200 0 5 0 0000215C
0 1 2 C3 64 0 5 0 000012C3
0 0 1 AA 40 1 4 1 00000000
0 0 1 3E 100 2 4 4 0000013E
1 1 1 AA 100 3 4 0 00003155
0 0 1 77 100 4 4 3 00000177

//--- sim.f
rtl/sdctrl_pkg.sv
rtl/sdctrl_cmd_if.sv
rtl/sdctrl_crc7.sv
rtl/sdctrl_regs.sv
rtl/sdctrl_init.sv
rtl/sdctrl_cmd_transmitter.sv
rtl/sdctrl.sv
dv/sd_card_model.sv
dv/tb_sdctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdctrl \
    -f sim.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
fi
exit $status
